//--- soc_pkg.sv
package soc_pkg;

	// ======================================================================
	// Address map fields
	// ======================================================================

	// Top nibble selects the target region
	localparam int REGION_LSB = 28;
	localparam int REGION_WIDTH = 4;

	// Byte offset within a 32-bit word
	localparam int WORD_LSB = 2;

	typedef logic [31:0] addr_t;
	typedef logic [31:0] data_t;

	// Mapped regions, all other nibble values are unmapped
	typedef enum logic [REGION_WIDTH-1:0] {
		REGION_RAM = 4'h1,
		REGION_LED = 4'h4
	} region_e;

	// Arbiter owner, one grant state per master
	typedef enum logic [1:0] {
		ARB_IDLE = 2'd0,
		ARB_IBUS = 2'd1,
		ARB_DBUS = 2'd2,
		ARB_DMA  = 2'd3
	} arb_state_e;

	// ======================================================================
	// Bus payloads
	// ======================================================================

	// Instruction fetch request, always a read
	typedef struct packed {
		logic  valid;
		addr_t addr;
	} fetch_req_t;

	// Data or DMA request, rw high for a write
	typedef struct packed {
		logic  valid;
		logic  rw;
		addr_t addr;
		data_t wdata;
	} bus_req_t;

	// Response back to a master, ready is a single-cycle pulse
	typedef struct packed {
		logic  ready;
		data_t rdata;
	} bus_rsp_t;

	// Request toward the targets, strobe is high for one cycle per transfer
	typedef struct packed {
		logic  strobe;
		logic  rw;
		addr_t addr;
		data_t wdata;
	} strobe_t;

endpackage

//--- bus_arbiter.sv
`timescale 1ns/100ps

module bus_arbiter (
	input  logic                clock,
	input  logic                i_arst_n,
	input  soc_pkg::fetch_req_t i_ibus,
	input  soc_pkg::bus_req_t   i_dbus,
	input  soc_pkg::bus_req_t   i_dma,
	input  soc_pkg::bus_rsp_t   i_rsp,
	output soc_pkg::bus_rsp_t   o_ibus_rsp,
	output soc_pkg::bus_rsp_t   o_dbus_rsp,
	output soc_pkg::bus_rsp_t   o_dma_rsp,
	output soc_pkg::strobe_t    o_strobe
);

	soc_pkg::arb_state_e state_q;
	soc_pkg::arb_state_e grant;
	logic                strobe_q;
	logic                rw_q;
	soc_pkg::addr_t      addr_q;
	soc_pkg::data_t      wdata_q;

	// Fixed priority: data, then fetch, then DMA
	always_comb begin
		if (i_dbus.valid) begin
			grant = soc_pkg::ARB_DBUS;
		end else if (i_ibus.valid) begin
			grant = soc_pkg::ARB_IBUS;
		end else if (i_dma.valid) begin
			grant = soc_pkg::ARB_DMA;
		end else begin
			grant = soc_pkg::ARB_IDLE;
		end
	end

	// ======================================================================
	// Owner FSM
	// ======================================================================

	always_ff @(posedge clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state_q  <= soc_pkg::ARB_IDLE;
			strobe_q <= 1'b0;
		end else begin
			// Strobe only in the first cycle of a grant
			strobe_q <= 1'b0;
			if (state_q == soc_pkg::ARB_IDLE) begin
				if (grant != soc_pkg::ARB_IDLE) begin
					state_q  <= grant;
					strobe_q <= 1'b1;
				end
			end else if (i_rsp.ready) begin
				state_q <= soc_pkg::ARB_IDLE;
			end
		end
	end

	// Latch the winner's fields, held for the whole transfer
	always_ff @(posedge clock) begin
		if (state_q == soc_pkg::ARB_IDLE) begin
			case (grant)
				soc_pkg::ARB_DBUS: begin
					rw_q    <= i_dbus.rw;
					addr_q  <= i_dbus.addr;
					wdata_q <= i_dbus.wdata;
				end
				soc_pkg::ARB_IBUS: begin
					rw_q    <= 1'b0;
					addr_q  <= i_ibus.addr;
					wdata_q <= '0;
				end
				soc_pkg::ARB_DMA: begin
					rw_q    <= i_dma.rw;
					addr_q  <= i_dma.addr;
					wdata_q <= i_dma.wdata;
				end
				default: begin
				end
			endcase
		end
	end

	assign o_strobe = '{strobe: strobe_q, rw: rw_q, addr: addr_q, wdata: wdata_q};

	// Response goes to the owner, everyone else sees zeros
	always_comb begin
		o_ibus_rsp = '0;
		o_dbus_rsp = '0;
		o_dma_rsp  = '0;
		case (state_q)
			soc_pkg::ARB_IBUS: o_ibus_rsp = i_rsp;
			soc_pkg::ARB_DBUS: o_dbus_rsp = i_rsp;
			soc_pkg::ARB_DMA:  o_dma_rsp  = i_rsp;
			default: begin
			end
		endcase
	end

endmodule

//--- block_ram.sv
`timescale 1ns/100ps

module block_ram #(
	parameter int RAM_DEPTH_WORDS = 1024
) (
	input  logic              clock,
	input  soc_pkg::strobe_t  i_strobe,
	output soc_pkg::bus_rsp_t o_rsp
);

	localparam int INDEX_WIDTH = $clog2(RAM_DEPTH_WORDS);

	soc_pkg::data_t         mem [RAM_DEPTH_WORDS];
	logic [INDEX_WIDTH-1:0] index;
	logic                   ready_q;
	soc_pkg::data_t         rdata_q;

	// Upper address bits are ignored, so the region wraps
	assign index = i_strobe.addr[soc_pkg::WORD_LSB +: INDEX_WIDTH];

	// Ready follows the strobe by one cycle
	always_ff @(posedge clock) begin
		ready_q <= i_strobe.strobe;
	end

	// A write returns the old word read in the same cycle
	always_ff @(posedge clock) begin
		if (i_strobe.strobe) begin
			rdata_q <= mem[index];
			if (i_strobe.rw) begin
				mem[index] <= i_strobe.wdata;
			end
		end
	end

	assign o_rsp = '{ready: ready_q, rdata: rdata_q};

endmodule

//--- system_bus.sv
`timescale 1ns/100ps

module system_bus #(
	parameter int LED_WIDTH = 10
) (
	input  logic                 clock,
	input  logic                 i_arst_n,
	input  soc_pkg::strobe_t     i_strobe,
	input  soc_pkg::bus_rsp_t    i_ram_rsp,
	output soc_pkg::strobe_t     o_ram_strobe,
	output soc_pkg::bus_rsp_t    o_rsp,
	output logic [LED_WIDTH-1:0] o_leds,
	output logic                 o_bus_fault
);

	soc_pkg::region_e     region;
	logic                 ram_select;
	logic                 led_select;
	logic [LED_WIDTH-1:0] led_q;
	logic                 local_ready_q;
	logic                 fault_q;
	soc_pkg::data_t       local_rdata_q;

	// ======================================================================
	// Region decode
	// ======================================================================

	assign region = soc_pkg::region_e'(
		i_strobe.addr[soc_pkg::REGION_LSB +: soc_pkg::REGION_WIDTH]);

	assign ram_select = (region == soc_pkg::REGION_RAM);
	assign led_select = (region == soc_pkg::REGION_LED);

	// RAM sees the strobe only for its own region
	always_comb begin
		o_ram_strobe        = i_strobe;
		o_ram_strobe.strobe = i_strobe.strobe && ram_select;
	end

	// ======================================================================
	// LED register
	// ======================================================================

	always_ff @(posedge clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			led_q <= '0;
		end else if (i_strobe.strobe && led_select && i_strobe.rw) begin
			led_q <= i_strobe.wdata[LED_WIDTH-1:0];
		end
	end

	assign o_leds = led_q;

	// ======================================================================
	// Local response for LED and unmapped accesses
	// ======================================================================

	always_ff @(posedge clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			local_ready_q <= 1'b0;
			fault_q       <= 1'b0;
		end else begin
			local_ready_q <= i_strobe.strobe && !ram_select;
			// Fault marks an unmapped access, same cycle as its ready
			fault_q       <= i_strobe.strobe && !ram_select && !led_select;
		end
	end

	// LED access returns the current value at any offset, unmapped reads zero
	always_ff @(posedge clock) begin
		if (i_strobe.strobe && !ram_select) begin
			if (led_select) begin
				local_rdata_q <= soc_pkg::data_t'(led_q);
			end else begin
				local_rdata_q <= '0;
			end
		end
	end

	assign o_bus_fault = fault_q;

	// Address is held by the arbiter until ready, so decode steers the mux
	always_comb begin
		if (ram_select) begin
			o_rsp = i_ram_rsp;
		end else begin
			o_rsp = '{ready: local_ready_q, rdata: local_rdata_q};
		end
	end

endmodule

//--- soc_fabric.sv
`timescale 1ns/100ps

module soc_fabric #(
	parameter int RAM_DEPTH_WORDS = 1024,
	parameter int LED_WIDTH = 10
) (
	input  logic                 clock,
	input  logic                 i_arst_n,
	input  soc_pkg::fetch_req_t  i_ibus,
	input  soc_pkg::bus_req_t    i_dbus,
	input  soc_pkg::bus_req_t    i_dma,
	output soc_pkg::bus_rsp_t    o_ibus_rsp,
	output soc_pkg::bus_rsp_t    o_dbus_rsp,
	output soc_pkg::bus_rsp_t    o_dma_rsp,
	output logic [LED_WIDTH-1:0] o_leds,
	output logic                 o_bus_fault
);

	// Shared single-port bus
	soc_pkg::strobe_t  bus_strobe;
	soc_pkg::bus_rsp_t bus_rsp;

	// RAM side of the decoder
	soc_pkg::strobe_t  ram_strobe;
	soc_pkg::bus_rsp_t ram_rsp;

	bus_arbiter arbiter0 (
		.clock      (clock),
		.i_arst_n   (i_arst_n),
		.i_ibus     (i_ibus),
		.i_dbus     (i_dbus),
		.i_dma      (i_dma),
		.i_rsp      (bus_rsp),
		.o_ibus_rsp (o_ibus_rsp),
		.o_dbus_rsp (o_dbus_rsp),
		.o_dma_rsp  (o_dma_rsp),
		.o_strobe   (bus_strobe)
	);

	system_bus #(
		.LED_WIDTH (LED_WIDTH)
	) bus0 (
		.clock        (clock),
		.i_arst_n     (i_arst_n),
		.i_strobe     (bus_strobe),
		.i_ram_rsp    (ram_rsp),
		.o_ram_strobe (ram_strobe),
		.o_rsp        (bus_rsp),
		.o_leds       (o_leds),
		.o_bus_fault  (o_bus_fault)
	);

	// Region 1
	block_ram #(
		.RAM_DEPTH_WORDS (RAM_DEPTH_WORDS)
	) ram0 (
		.clock    (clock),
		.i_strobe (ram_strobe),
		.o_rsp    (ram_rsp)
	);

endmodule

//--- soc_fabric_sva.sv
`timescale 1ns/100ps

module arb_sva (
	input logic              clock,
	input logic              i_arst_n,
	input soc_pkg::strobe_t  o_strobe,
	input soc_pkg::bus_rsp_t i_rsp,
	input soc_pkg::bus_rsp_t o_ibus_rsp,
	input soc_pkg::bus_rsp_t o_dbus_rsp,
	input soc_pkg::bus_rsp_t o_dma_rsp
);

	// One strobe per transfer, never a held level
	strobe_single: assert property (@(posedge clock) disable iff (!i_arst_n)
		o_strobe.strobe |=> !o_strobe.strobe)
		else $error("strobe stayed high for two cycles");

	// Response reaches the owner only
	ready_owner_only: assert property (@(posedge clock) disable iff (!i_arst_n)
		$onehot0({o_ibus_rsp.ready, o_dbus_rsp.ready, o_dma_rsp.ready}))
		else $error("more than one master ready at once");

	// Every target answers one cycle after the strobe
	strobe_then_ready: assert property (@(posedge clock) disable iff (!i_arst_n)
		o_strobe.strobe |=> i_rsp.ready)
		else $error("no ready one cycle after the strobe");

	// And a ready never shows up on its own
	ready_after_strobe: assert property (@(posedge clock) disable iff (!i_arst_n)
		i_rsp.ready |-> $past(o_strobe.strobe))
		else $error("ready without a strobe in the cycle before");

endmodule

bind bus_arbiter arb_sva arb_sva0 (
	.clock      (clock),
	.i_arst_n   (i_arst_n),
	.o_strobe   (o_strobe),
	.i_rsp      (i_rsp),
	.o_ibus_rsp (o_ibus_rsp),
	.o_dbus_rsp (o_dbus_rsp),
	.o_dma_rsp  (o_dma_rsp)
);

//--- tb_soc_fabric.sv
`timescale 1ns/100ps

module tb_soc_fabric;

	localparam int RAM_DEPTH_WORDS = 1024;
	localparam int LED_WIDTH = 10;
	localparam int RESET_CYCLES = 10;
	localparam int RAND_WORDS = 16;
	localparam int DMA_WORDS = 8;
	localparam int LED_ROUNDS = 2;
	localparam int FAULT_ACCESSES = 6;
	localparam int ALIAS_PAIRS = 2;
	localparam int NUM_TRANSFERS = 2 * RAND_WORDS + 2 * DMA_WORDS + 2 * LED_ROUNDS
		+ FAULT_ACCESSES + 3 + 2 * ALIAS_PAIRS;
	localparam int TIMEOUT_CYCLES = 2 * (4 * NUM_TRANSFERS + RESET_CYCLES);

	// Expected outcome of one transfer
	typedef struct packed {
		soc_pkg::arb_state_e  port;
		logic                 check_rdata;
		logic                 fault;
		logic [LED_WIDTH-1:0] leds;
		soc_pkg::bus_rsp_t    rsp;
	} expect_t;

	logic                 clock;
	logic                 i_arst_n;
	soc_pkg::fetch_req_t  ibus_req;
	soc_pkg::bus_req_t    dbus_req;
	soc_pkg::bus_req_t    dma_req;
	soc_pkg::bus_rsp_t    ibus_rsp;
	soc_pkg::bus_rsp_t    dbus_rsp;
	soc_pkg::bus_rsp_t    dma_rsp;
	logic [LED_WIDTH-1:0] leds;
	logic                 bus_fault;

	logic [31:0]          lfsr_state;
	int                   cycle_count;
	expect_t              expect_q [$];
	soc_pkg::data_t       ram_model [RAM_DEPTH_WORDS];
	logic                 ram_written [RAM_DEPTH_WORDS];
	logic [LED_WIDTH-1:0] led_model;

	soc_fabric #(
		.RAM_DEPTH_WORDS (RAM_DEPTH_WORDS),
		.LED_WIDTH       (LED_WIDTH)
	) dut0 (
		.clock       (clock),
		.i_arst_n    (i_arst_n),
		.i_ibus      (ibus_req),
		.i_dbus      (dbus_req),
		.i_dma       (dma_req),
		.o_ibus_rsp  (ibus_rsp),
		.o_dbus_rsp  (dbus_rsp),
		.o_dma_rsp   (dma_rsp),
		.o_leds      (leds),
		.o_bus_fault (bus_fault)
	);

	always #2 clock = ~clock;

	// ======================================================================
	// Failure, random bits and address helpers
	// ======================================================================

	task automatic stop_with_failure(input string msg);
		$display("%s", msg);
		$display("TESTS FAILED");
		$fatal(1);
	endtask

	// Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
	function automatic logic [31:0] take_bits(input int count);
		logic [31:0] value;
		logic        feedback;
		value = '0;
		for (int i = 0; i < count; i++) begin
			feedback = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], feedback};
			value = {value[30:0], feedback};
		end
		return value;
	endfunction

	function automatic soc_pkg::addr_t ram_addr();
		logic [31:0] bits;
		bits = take_bits(26);
		return {4'h1, bits[25:0], 2'b00};
	endfunction

	function automatic soc_pkg::addr_t led_addr();
		logic [31:0] bits;
		bits = take_bits(28);
		return {4'h4, bits[27:0]};
	endfunction

	function automatic soc_pkg::addr_t unmapped_addr();
		logic [31:0] region;
		logic [31:0] bits;
		region = take_bits(4);
		while (region == 32'h1 || region == 32'h4) begin
			region = take_bits(4);
		end
		bits = take_bits(28);
		return {region[3:0], bits[27:0]};
	endfunction

	// ======================================================================
	// Reference model
	// ======================================================================

	// RAM wraps every RAM_DEPTH_WORDS words and a write returns the old word
	function automatic expect_t model_access(input soc_pkg::arb_state_e port, input logic rw,
			input soc_pkg::addr_t addr, input soc_pkg::data_t wdata);
		expect_t     e;
		int unsigned index;
		logic [3:0]  region;
		region = addr[31:28];
		index = (addr >> soc_pkg::WORD_LSB) % RAM_DEPTH_WORDS;
		e = '0;
		e.port = port;
		e.rsp.ready = 1'b1;
		if (region == 4'h1) begin
			e.check_rdata = !rw || ram_written[index];
			e.rsp.rdata = ram_model[index];
			if (rw) begin
				ram_model[index] = wdata;
				ram_written[index] = 1'b1;
			end
		end else if (region == 4'h4) begin
			e.check_rdata = !rw;
			e.rsp.rdata = soc_pkg::data_t'(led_model);
			if (rw) begin
				led_model = wdata[LED_WIDTH-1:0];
			end
		end else begin
			// Unmapped region gives zero data and the fault flag
			e.check_rdata = 1'b1;
			e.rsp.rdata = '0;
			e.fault = 1'b1;
		end
		e.leds = led_model;
		return e;
	endfunction

	function automatic soc_pkg::bus_rsp_t rsp_of(input soc_pkg::arb_state_e port);
		case (port)
			soc_pkg::ARB_IBUS: return ibus_rsp;
			soc_pkg::ARB_DBUS: return dbus_rsp;
			soc_pkg::ARB_DMA:  return dma_rsp;
			default:           return '0;
		endcase
	endfunction

	function automatic string port_name(input soc_pkg::arb_state_e port);
		case (port)
			soc_pkg::ARB_IBUS: return "o_ibus_rsp";
			soc_pkg::ARB_DBUS: return "o_dbus_rsp";
			soc_pkg::ARB_DMA:  return "o_dma_rsp";
			default:           return "no_port";
		endcase
	endfunction

	// ======================================================================
	// Compare tasks and the checking process
	// ======================================================================

	task automatic compare_rsp(input string name, input soc_pkg::bus_rsp_t got,
			input soc_pkg::bus_rsp_t exp, input logic check_rdata);
		if (got.ready !== exp.ready) begin
			stop_with_failure($sformatf("mismatch %s.ready expected %h got %h",
				name, exp.ready, got.ready));
		end else if (check_rdata && got.rdata !== exp.rdata) begin
			stop_with_failure($sformatf("mismatch %s.rdata expected %h got %h",
				name, exp.rdata, got.rdata));
		end
	endtask

	task automatic compare_leds(input logic [LED_WIDTH-1:0] got, input logic [LED_WIDTH-1:0] exp);
		if (got !== exp) begin
			stop_with_failure($sformatf("mismatch o_leds expected %h got %h", exp, got));
		end
	endtask

	task automatic compare_fault(input logic got, input logic exp);
		if (got !== exp) begin
			stop_with_failure($sformatf("mismatch o_bus_fault expected %h got %h", exp, got));
		end
	endtask

	task automatic compare_latency(input string name, input int got, input int exp);
		if (got != exp) begin
			stop_with_failure($sformatf("mismatch %s latency expected %h got %h",
				name, exp, got));
		end
	endtask

	// The oldest outstanding transfer names the port that must see ready
	task automatic check_responses();
		int      readies;
		expect_t e;
		readies = 0;
		if (ibus_rsp.ready === 1'b1) begin
			readies++;
		end
		if (dbus_rsp.ready === 1'b1) begin
			readies++;
		end
		if (dma_rsp.ready === 1'b1) begin
			readies++;
		end
		if (readies > 1) begin
			stop_with_failure("more than one master saw ready in the same cycle");
		end else if (readies == 0) begin
			compare_fault(bus_fault, 1'b0);
		end else if (expect_q.size() == 0) begin
			stop_with_failure("a master saw ready with no transfer outstanding");
		end else begin
			e = expect_q.pop_front();
			compare_rsp(port_name(e.port), rsp_of(e.port), e.rsp, e.check_rdata);
			compare_fault(bus_fault, e.fault);
			compare_leds(leds, e.leds);
		end
	endtask

	// Outputs are stable by the falling edge
	always @(negedge clock) begin
		if (i_arst_n) begin
			check_responses();
		end
	end

	always @(posedge clock) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			stop_with_failure($sformatf("timeout after %0d cycles, a transfer never completed",
				cycle_count));
		end
	end

	// ======================================================================
	// Master drivers
	// ======================================================================

	task automatic drive_req(input soc_pkg::arb_state_e port, input logic valid, input logic rw,
			input soc_pkg::addr_t addr, input soc_pkg::data_t wdata);
		case (port)
			soc_pkg::ARB_IBUS: ibus_req = '{valid: valid, addr: addr};
			soc_pkg::ARB_DBUS: dbus_req = '{valid: valid, rw: rw, addr: addr, wdata: wdata};
			soc_pkg::ARB_DMA:  dma_req = '{valid: valid, rw: rw, addr: addr, wdata: wdata};
			default: begin
			end
		endcase
	endtask

	// Hold the request until ready and release it one edge later
	task automatic run_port(input soc_pkg::arb_state_e port, input logic rw,
			input soc_pkg::addr_t addr, input soc_pkg::data_t wdata, input int exp_latency);
		int                latency;
		soc_pkg::bus_rsp_t rsp;
		latency = 0;
		drive_req(port, 1'b1, rw, addr, wdata);
		forever begin
			@(posedge clock);
			#1;
			latency++;
			rsp = rsp_of(port);
			if (rsp.ready === 1'b1) begin
				break;
			end
		end
		compare_latency(port_name(port), latency, exp_latency);
		@(posedge clock);
		#1;
		drive_req(port, 1'b0, 1'b0, '0, '0);
	endtask

	task automatic transfer(input soc_pkg::arb_state_e port, input logic rw,
			input soc_pkg::addr_t addr, input soc_pkg::data_t wdata);
		expect_q.push_back(model_access(port, rw, addr, wdata));
		run_port(port, rw, addr, wdata, 2);
	endtask

	// ======================================================================
	// Tests
	// ======================================================================

	task automatic test_ram_random();
		soc_pkg::addr_t addrs [RAND_WORDS];
		for (int i = 0; i < RAND_WORDS; i++) begin
			addrs[i] = ram_addr();
			transfer(soc_pkg::ARB_DBUS, 1'b1, addrs[i], take_bits(32));
		end
		for (int i = 0; i < RAND_WORDS; i++) begin
			transfer(soc_pkg::ARB_DBUS, 1'b0, addrs[i], '0);
		end
	endtask

	task automatic test_dma_fetch();
		soc_pkg::addr_t addrs [DMA_WORDS];
		for (int i = 0; i < DMA_WORDS; i++) begin
			addrs[i] = ram_addr();
			transfer(soc_pkg::ARB_DMA, 1'b1, addrs[i], take_bits(32));
		end
		for (int i = 0; i < DMA_WORDS; i++) begin
			transfer(soc_pkg::ARB_IBUS, 1'b0, addrs[i], '0);
		end
	endtask

	task automatic test_leds();
		for (int i = 0; i < LED_ROUNDS; i++) begin
			transfer(soc_pkg::ARB_DBUS, 1'b1, led_addr(), take_bits(32));
			transfer(soc_pkg::ARB_DBUS, 1'b0, led_addr(), '0);
		end
	endtask

	task automatic test_unmapped();
		soc_pkg::arb_state_e port;
		for (int i = 0; i < FAULT_ACCESSES; i++) begin
			port = (i % 3 == 0) ? soc_pkg::ARB_DBUS : (i % 3 == 1) ? soc_pkg::ARB_IBUS
				: soc_pkg::ARB_DMA;
			transfer(port, port == soc_pkg::ARB_DBUS, unmapped_addr(), take_bits(32));
		end
	endtask

	// Grants go to data, fetch and DMA in turn when all three ask at once
	task automatic test_contention();
		soc_pkg::addr_t shared_addr;
		soc_pkg::addr_t leds_addr;
		soc_pkg::data_t wdata;
		shared_addr = ram_addr();
		leds_addr = led_addr();
		wdata = take_bits(32);
		expect_q.push_back(model_access(soc_pkg::ARB_DBUS, 1'b1, shared_addr, wdata));
		expect_q.push_back(model_access(soc_pkg::ARB_IBUS, 1'b0, shared_addr, '0));
		expect_q.push_back(model_access(soc_pkg::ARB_DMA, 1'b0, leds_addr, '0));
		fork
			run_port(soc_pkg::ARB_DBUS, 1'b1, shared_addr, wdata, 2);
			run_port(soc_pkg::ARB_IBUS, 1'b0, shared_addr, '0, 5);
			run_port(soc_pkg::ARB_DMA, 1'b0, leds_addr, '0, 8);
		join
	endtask

	task automatic test_alias();
		soc_pkg::addr_t first;
		soc_pkg::addr_t offset;
		offset = soc_pkg::addr_t'(RAM_DEPTH_WORDS) << soc_pkg::WORD_LSB;
		for (int i = 0; i < ALIAS_PAIRS; i++) begin
			first = ram_addr();
			transfer(soc_pkg::ARB_DBUS, 1'b1, first, take_bits(32));
			transfer(soc_pkg::ARB_DBUS, 1'b0, first ^ offset, '0);
		end
	endtask

	initial begin
		clock = 1'b0;
		i_arst_n = 1'b0;
		ibus_req = '0;
		dbus_req = '0;
		dma_req = '0;
		cycle_count = 0;
		lfsr_state = 32'he4d5_1ebb;
		led_model = '0;
		for (int i = 0; i < RAM_DEPTH_WORDS; i++) begin
			ram_written[i] = 1'b0;
		end
		repeat (RESET_CYCLES) @(posedge clock);
		#1;
		i_arst_n = 1'b1;
		@(posedge clock);
		#1;
		test_ram_random();
		test_dma_fetch();
		test_leds();
		test_unmapped();
		test_contention();
		test_alias();
		repeat (2) @(posedge clock);
		if (expect_q.size() != 0) begin
			stop_with_failure("some transfers never returned a ready");
		end else begin
			$display("TESTS PASSED");
			$finish;
		end
	end

endmodule

//--- src.f
soc_pkg.sv
bus_arbiter.sv
block_ram.sv
system_bus.sv
soc_fabric.sv
soc_fabric_sva.sv
tb_soc_fabric.sv

//--- Bender.yml
package:
  name: soc_fabric

sources:
  - soc_pkg.sv
  - bus_arbiter.sv
  - block_ram.sv
  - system_bus.sv
  - soc_fabric.sv
  - target: test
    files:
      - soc_fabric_sva.sv
      - tb_soc_fabric.sv
